// File: src/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// word address, the byte offset is carried by the enables
	typedef logic [29:0] word_addr_t;

	typedef struct packed {
		word_addr_t  addr;
		logic [3:0]  be;
		logic [31:0] wdata;
	} data_memreq_t;

	typedef struct packed {
		logic       valid;
		word_addr_t addr;
	} load_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] rdata;
	} load_resp_t;

endpackage

`default_nettype wire

// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;
	import mem_pkg::*;

	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] uint32_t;
	typedef logic [31:0] virt_t;

	typedef enum logic [2:0] {
		FU_ALU    = 3'd0,
		FU_MUL    = 3'd1,
		FU_CP0    = 3'd2,
		FU_STORE  = 3'd3,
		FU_BRANCH = 3'd4
	} fu_t;

	// cause codes as in the MIPS32 cause register
	typedef enum logic [4:0] {
		EXC_INT  = 5'h00,
		EXC_ADEL = 5'h04,
		EXC_ADES = 5'h05,
		EXC_SYS  = 5'h08,
		EXC_BP   = 5'h09,
		EXC_RI   = 5'h0a,
		EXC_OV   = 5'h0c,
		EXC_NONE = 5'h1f
	} exc_code_t;

	typedef struct packed {
		logic  valid;
		logic  taken;
		virt_t pc;
		virt_t target;
	} branch_resolved_t;

	// a store request or a branch record, selected by fu
	typedef union packed {
		data_memreq_t     memreq;
		branch_resolved_t resolved_branch;
	} rob_payload_t;

	typedef struct packed {
		logic         valid;
		logic         busy;
		reg_addr_t    dest;
		uint32_t      value;
		virt_t        pc;
		fu_t          fu;
		exc_code_t    exc;
		rob_payload_t data;
	} rob_entry_t;

	// slot 0 holds the older entry
	typedef rob_entry_t [1:0] rob_packet_t;

	typedef struct packed {
		logic      valid;
		logic      alpha_taken;
		exc_code_t code;
		virt_t     pc;
	} except_req_t;

	typedef struct packed {
		logic       ie;
		logic [7:0] im;
	} cp0_status_t;

endpackage

`default_nettype wire

// File: src/reorder_buffer.sv
`default_nettype none
`timescale 1ns/10ps

module reorder_buffer import cpu_pkg::*; #(
	parameter int ROB_DEPTH = 16
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         dispatch_valid,
	input  rob_entry_t                   dispatch_entry,
	output logic [$clog2(ROB_DEPTH)-1:0] dispatch_index,
	output logic                         rob_full,
	input  logic                         wb_valid,
	input  logic [$clog2(ROB_DEPTH)-1:0] wb_index,
	input  uint32_t                      wb_value,
	output logic                         rob_empty,
	output rob_packet_t                  rob_packet,
	input  logic                         rob_ack,
	input  logic                         flush
);

	localparam int IDX_W = $clog2(ROB_DEPTH);

	typedef logic [IDX_W-1:0] rob_index_t;
	typedef logic [IDX_W:0]   rob_count_t;

	rob_entry_t entries [ROB_DEPTH];
	rob_index_t head, tail, head_next, wb_offset;
	rob_count_t count, count_next;
	logic       do_dispatch;
	logic [1:0] retire_num;

	assign do_dispatch    = dispatch_valid & ~rob_full;
	assign dispatch_index = tail;
	assign head_next      = head + rob_index_t'(1);
	assign rob_empty      = (count == '0);

	// two oldest entries, masked by occupancy
	always_comb begin
		rob_packet[0] = entries[head];
		rob_packet[1] = entries[head_next];
		if (count == '0) begin
			rob_packet[0].valid = 1'b0;
			rob_packet[0].busy  = 1'b0;
		end
		if (count < rob_count_t'(2)) begin
			rob_packet[1].valid = 1'b0;
			rob_packet[1].busy  = 1'b0;
		end
	end

	assign retire_num = rob_ack ? (rob_packet[1].valid ? 2'd2 : 2'd1) : 2'd0;
	assign count_next = count + rob_count_t'(do_dispatch) - rob_count_t'(retire_num);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			head     <= '0;
			tail     <= '0;
			count    <= '0;
			rob_full <= 1'b0;
		end else begin
			head     <= head + rob_index_t'(retire_num);
			tail     <= tail + rob_index_t'(do_dispatch);
			count    <= count_next;
			rob_full <= (count_next == rob_count_t'(ROB_DEPTH));
		end
	end

	always_ff @(posedge clk) begin
		if (do_dispatch) begin
			entries[tail]       <= dispatch_entry;
			entries[tail].valid <= 1'b1;
			entries[tail].busy  <= 1'b1;
		end
		// completion from any functional unit
		if (wb_valid) begin
			entries[wb_index].busy  <= 1'b0;
			entries[wb_index].value <= wb_value;
		end
	end

	// distance from head, must fall inside the occupied window
	assign wb_offset = wb_index - head;

	a_no_dispatch_full: assert property (@(posedge clk) disable iff (reset)
		!(dispatch_valid && rob_full));

	a_wb_in_flight: assert property (@(posedge clk) disable iff (reset)
		wb_valid |-> (rob_count_t'(wb_offset) < count));

endmodule

`default_nettype wire

// File: src/except_detect.sv
`default_nettype none
`timescale 1ns/10ps

module except_detect import cpu_pkg::*; (
	input  rob_packet_t  rob_packet,
	input  cp0_status_t  cp0_status,
	input  logic [7:0]   interrupt_flag,
	output except_req_t  except_req
);

	logic int_pending;
	logic [1:0] slot_exc;

	// interrupts are taken on the oldest instruction
	assign int_pending = cp0_status.ie & (|(interrupt_flag & cp0_status.im))
		& rob_packet[0].valid;

	assign slot_exc[0] = rob_packet[0].valid && (rob_packet[0].exc != EXC_NONE);
	assign slot_exc[1] = rob_packet[1].valid && (rob_packet[1].exc != EXC_NONE);

	always_comb begin
		except_req = '0;
		if (int_pending) begin
			except_req.valid       = 1'b1;
			except_req.alpha_taken = 1'b1;
			except_req.code        = EXC_INT;
			except_req.pc          = rob_packet[0].pc;
		end else if (slot_exc[0]) begin
			except_req.valid       = 1'b1;
			except_req.alpha_taken = 1'b1;
			except_req.code        = rob_packet[0].exc;
			except_req.pc          = rob_packet[0].pc;
		end else if (slot_exc[1]) begin
			// older slot still retires
			except_req.valid       = 1'b1;
			except_req.alpha_taken = 1'b0;
			except_req.code        = rob_packet[1].exc;
			except_req.pc          = rob_packet[1].pc;
		end
	end

endmodule

`default_nettype wire

// File: src/instr_commit.sv
`default_nettype none
`timescale 1ns/10ps

module instr_commit import mem_pkg::*, cpu_pkg::*; #(
	parameter virt_t EXC_VECTOR = 32'hbfc0_0380
) (
	input  rob_packet_t       rob_packet,
	input  logic              rob_empty,
	output logic              rob_ack,
	input  except_req_t       except_req,
	output logic [1:0]        reg_we,
	output reg_addr_t [1:0]   reg_waddr,
	output uint32_t [1:0]     reg_wdata,
	output branch_resolved_t  resolved_branch,
	output data_memreq_t      lsu_store_memreq,
	output logic              lsu_store_push,
	input  logic              lsu_store_full,
	output logic              commit_mul,
	output logic              commit_cp0,
	output logic              commit_flush,
	output virt_t             commit_flush_pc
);

	logic [1:0] is_store, is_mul, is_cp0, slot_ok;
	logic       is_branch, packet_ready, store_request;

	// slot 0 dies with its own exception and slot 1 with any
	assign slot_ok[0] = ~(except_req.valid & except_req.alpha_taken);
	assign slot_ok[1] = ~except_req.valid;

	for (genvar i = 0; i < 2; i++) begin : gen_slot
		assign is_store[i]  = rob_packet[i].valid && (rob_packet[i].fu == FU_STORE);
		assign is_mul[i]    = rob_packet[i].valid && (rob_packet[i].fu == FU_MUL);
		assign is_cp0[i]    = rob_packet[i].valid && (rob_packet[i].fu == FU_CP0);
		assign reg_we[i]    = rob_ack & rob_packet[i].valid & slot_ok[i];
		assign reg_waddr[i] = rob_packet[i].dest;
		assign reg_wdata[i] = rob_packet[i].value;
	end

	assign is_branch    = rob_packet[0].valid && (rob_packet[0].fu == FU_BRANCH);
	assign packet_ready = ~rob_empty & ~rob_packet[0].busy & ~rob_packet[1].busy;

	assign store_request = |(is_store & slot_ok);

	// hold the packet while the queue cannot take its store
	assign rob_ack = packet_ready & (~store_request | ~lsu_store_full);

	assign lsu_store_push   = packet_ready & store_request & ~lsu_store_full;
	assign lsu_store_memreq = is_store[1] ? rob_packet[1].data.memreq
		: rob_packet[0].data.memreq;

	assign commit_mul = rob_ack & (|(is_mul & slot_ok));
	assign commit_cp0 = rob_ack & (|(is_cp0 & slot_ok));

	assign resolved_branch = (rob_ack & is_branch & slot_ok[0])
		? rob_packet[0].data.resolved_branch : '0;

	assign commit_flush    = rob_ack & except_req.valid;
	assign commit_flush_pc = EXC_VECTOR;

	// queue accepts one store per cycle
	always_comb begin
		a_one_store: assert final (!(is_store[0] === 1'b1 && is_store[1] === 1'b1));
	end

endmodule

`default_nettype wire

// File: src/store_queue.sv
`default_nettype none
`timescale 1ns/10ps

module store_queue import mem_pkg::*; #(
	parameter int SQ_DEPTH = 4
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         push,
	input  data_memreq_t push_req,
	input  logic         pop,
	output logic         full,
	output logic         empty,
	output logic         head_valid,
	output data_memreq_t head_req
);

	localparam int PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(SQ_DEPTH + 1);

	data_memreq_t     slots [SQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push, do_pop;

	// wrap at depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(SQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full       = (count == CNT_W'(SQ_DEPTH));
	assign empty      = (count == '0);
	assign head_valid = ~empty;
	assign head_req   = slots[rd_ptr];

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			slots[wr_ptr] <= push_req;
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (reset) !(push && full));

	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

`default_nettype wire

// File: src/shared_dmem.sv
`default_nettype none
`timescale 1ns/10ps

module shared_dmem import mem_pkg::*; #(
	parameter int DMEM_WORDS = 256
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         sq_valid,
	input  data_memreq_t sq_req,
	output logic         sq_pop,
	input  load_req_t    load_req,
	output load_resp_t   load_resp
);

	localparam int AW = $clog2(DMEM_WORDS);

	logic [31:0]   ram [DMEM_WORDS];
	logic [AW-1:0] store_addr, load_addr;
	logic          load_grant, store_grant;
	logic          resp_valid;
	logic [31:0]   resp_data;

	// loads win and the drain waits for a free cycle
	assign load_grant  = load_req.valid;
	assign store_grant = sq_valid & ~load_req.valid;
	assign sq_pop      = store_grant;

	assign store_addr = sq_req.addr[AW-1:0];
	assign load_addr  = load_req.addr[AW-1:0];

	always_ff @(posedge clk) begin
		if (store_grant) begin
			for (int b = 0; b < 4; b++) begin
				if (sq_req.be[b])
					ram[store_addr][8*b +: 8] <= sq_req.wdata[8*b +: 8];
			end
		end
		if (load_grant)
			resp_data <= ram[load_addr];
	end

	always_ff @(posedge clk) begin
		if (reset)
			resp_valid <= 1'b0;
		else
			resp_valid <= load_grant;
	end

	assign load_resp.valid = resp_valid;
	assign load_resp.rdata = resp_data;

endmodule

`default_nettype wire

// File: src/commit_top.sv
`default_nettype none
`timescale 1ns/10ps

module commit_top import mem_pkg::*, cpu_pkg::*; #(
	parameter int    ROB_DEPTH  = 16,
	parameter int    SQ_DEPTH   = 4,
	parameter int    DMEM_WORDS = 256,
	parameter virt_t EXC_VECTOR = 32'hbfc0_0380
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         dispatch_valid,
	input  rob_entry_t                   dispatch_entry,
	output logic [$clog2(ROB_DEPTH)-1:0] dispatch_index,
	output logic                         rob_full,
	input  logic                         wb_valid,
	input  logic [$clog2(ROB_DEPTH)-1:0] wb_index,
	input  uint32_t                      wb_value,
	input  cp0_status_t                  cp0_status,
	input  logic [7:0]                   interrupt_flag,
	output logic                         rob_ack,
	output logic [1:0]                   reg_we,
	output reg_addr_t [1:0]              reg_waddr,
	output uint32_t [1:0]                reg_wdata,
	output branch_resolved_t             resolved_branch,
	output data_memreq_t                 lsu_store_memreq,
	output logic                         lsu_store_push,
	output logic                         commit_mul,
	output logic                         commit_cp0,
	output logic                         commit_flush,
	output virt_t                        commit_flush_pc,
	input  load_req_t                    load_req,
	output load_resp_t                   load_resp,
	output logic                         sq_empty
);

	rob_packet_t  rob_packet;
	logic         rob_empty;
	except_req_t  except_req;
	logic         sq_full, sq_valid, sq_pop;
	data_memreq_t sq_req;

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob_inst (
		.clk, .reset,
		.dispatch_valid, .dispatch_entry, .dispatch_index, .rob_full,
		.wb_valid, .wb_index, .wb_value,
		.rob_empty, .rob_packet, .rob_ack,
		.flush ( commit_flush )
	);

	except_detect except_inst (
		.rob_packet, .cp0_status, .interrupt_flag, .except_req
	);

	instr_commit #(.EXC_VECTOR(EXC_VECTOR)) commit_inst (
		.rob_packet, .rob_empty, .rob_ack, .except_req,
		.reg_we, .reg_waddr, .reg_wdata, .resolved_branch,
		.lsu_store_memreq, .lsu_store_push,
		.lsu_store_full ( sq_full ),
		.commit_mul, .commit_cp0, .commit_flush, .commit_flush_pc
	);

	store_queue #(.SQ_DEPTH(SQ_DEPTH)) sq_inst (
		.clk, .reset,
		.push       ( lsu_store_push ),
		.push_req   ( lsu_store_memreq ),
		.pop        ( sq_pop ),
		.full       ( sq_full ),
		.empty      ( sq_empty ),
		.head_valid ( sq_valid ),
		.head_req   ( sq_req )
	);

	shared_dmem #(.DMEM_WORDS(DMEM_WORDS)) dmem_inst (
		.clk, .reset, .sq_valid, .sq_req, .sq_pop, .load_req, .load_resp
	);

endmodule

`default_nettype wire

// File: tb/commit_tb.sv
`default_nettype none
`timescale 1ns/10ps

module commit_tb import mem_pkg::*, cpu_pkg::*; ();

	localparam int    SQ_DEPTH   = 4;
	localparam virt_t EXC_VECTOR = 32'hbfc0_0380;
	localparam int    TIMEOUT    = 200;

	logic             clk, reset;
	logic             dispatch_valid, rob_full;
	rob_entry_t       dispatch_entry;
	logic [3:0]       dispatch_index, wb_index;
	logic             wb_valid;
	uint32_t          wb_value;
	cp0_status_t      cp0_status;
	logic [7:0]       interrupt_flag;
	logic             rob_ack;
	logic [1:0]       reg_we;
	reg_addr_t [1:0]  reg_waddr;
	uint32_t [1:0]    reg_wdata;
	branch_resolved_t resolved_branch;
	data_memreq_t     lsu_store_memreq;
	logic             lsu_store_push, commit_mul, commit_cp0, commit_flush;
	virt_t            commit_flush_pc;
	load_req_t        load_req;
	load_resp_t       load_resp;
	logic             sq_empty;

	// reference model in program order from exp_head to exp_tail
	integer           seed;
	rob_entry_t       exp_mem [256];
	logic [3:0]       exp_idx [256];
	int               exp_head, exp_tail;
	logic [31:0]      mem_model [256];
	logic [31:0]      exp_load_data;
	logic             exp_load_check, check_load, burst_phase;
	int               burst_pushes, flush_count;
	int               order [16];

	rob_entry_t       e0, e1;
	logic             two, int_on, exc0, exc1, ok0, ok1;
	logic             exp_we0, exp_we1, exp_flush, exp_mul, exp_cp0, exp_store;
	data_memreq_t     exp_memreq;
	branch_resolved_t exp_branch;

	commit_top #(
		.ROB_DEPTH(16), .SQ_DEPTH(SQ_DEPTH), .DMEM_WORDS(256), .EXC_VECTOR(EXC_VECTOR)
	) uut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	assign e0     = exp_mem[exp_head[7:0]];
	assign e1     = exp_mem[8'(exp_head + 1)];
	assign two    = (exp_tail - exp_head) >= 2;
	assign int_on = cp0_status.ie && (|(interrupt_flag & cp0_status.im));
	assign exc0   = int_on || (e0.exc != EXC_NONE);
	assign exc1   = two && (e1.exc != EXC_NONE);
	assign ok0    = (exp_tail != exp_head) && !exc0;
	assign ok1    = two && !exc0 && !exc1;

	assign exp_we0    = rob_ack && ok0;
	assign exp_we1    = rob_ack && ok1;
	assign exp_flush  = rob_ack && (exc0 || exc1);
	assign exp_mul    = rob_ack && ((ok0 && e0.fu == FU_MUL) || (ok1 && e1.fu == FU_MUL));
	assign exp_cp0    = rob_ack && ((ok0 && e0.fu == FU_CP0) || (ok1 && e1.fu == FU_CP0));
	assign exp_store  = (ok0 && e0.fu == FU_STORE) || (ok1 && e1.fu == FU_STORE);
	assign exp_memreq = (ok1 && e1.fu == FU_STORE) ? e1.data.memreq : e0.data.memreq;
	assign exp_branch = (rob_ack && ok0 && e0.fu == FU_BRANCH) ? e0.data.resolved_branch : '0;

	task automatic value_error(input string name, input logic [95:0] got,
		input logic [95:0] exp);
		$display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_error(input string what);
		$display("Check failed: %s", what);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic timeout_error(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	// entries leave the model only on observed commits
	always @(posedge clk) begin
		if (reset) begin
			exp_load_check <= 1'b0;
		end else begin
			exp_load_check <= load_req.valid && check_load;
			if (load_req.valid)
				exp_load_data <= mem_model[load_req.addr[7:0]];
			if (lsu_store_push) begin
				for (int b = 0; b < 4; b++)
					if (lsu_store_memreq.be[b])
						mem_model[lsu_store_memreq.addr[7:0]][8*b +: 8] =
							lsu_store_memreq.wdata[8*b +: 8];
				burst_pushes++;
			end
			if (commit_flush) begin
				exp_head = exp_tail;
				flush_count++;
			end else if (rob_ack) begin
				exp_head = exp_head + (two ? 2 : 1);
			end
		end
	end

	a_reset_idle: assert property (@(posedge clk) $fell(reset) |-> (!rob_ack
		&& reg_we == 2'b00 && !lsu_store_push && !commit_mul && !commit_cp0
		&& !commit_flush && !rob_full && !load_resp.valid && sq_empty))
		else check_error("control outputs not idle after reset");
	a_ack_ready: assert property (@(posedge clk) disable iff (reset)
		rob_ack |-> (exp_tail != exp_head && !e0.busy && !(two && e1.busy)))
		else check_error("commit of a busy or missing entry");
	a_we: assert property (@(posedge clk) disable iff (reset) reg_we == {exp_we1, exp_we0})
		else value_error("reg_we", $sampled(reg_we), $sampled({exp_we1, exp_we0}));
	a_waddr0: assert property (@(posedge clk) disable iff (reset)
		reg_we[0] |-> (reg_waddr[0] == e0.dest && reg_wdata[0] == e0.value))
		else value_error("reg_waddr/reg_wdata[0]", $sampled({reg_waddr[0], reg_wdata[0]}),
			$sampled({e0.dest, e0.value}));
	a_waddr1: assert property (@(posedge clk) disable iff (reset)
		reg_we[1] |-> (reg_waddr[1] == e1.dest && reg_wdata[1] == e1.value))
		else value_error("reg_waddr/reg_wdata[1]", $sampled({reg_waddr[1], reg_wdata[1]}),
			$sampled({e1.dest, e1.value}));
	a_flush: assert property (@(posedge clk) disable iff (reset) commit_flush == exp_flush)
		else value_error("commit_flush", $sampled(commit_flush), $sampled(exp_flush));
	a_flush_pc: assert property (@(posedge clk) disable iff (reset)
		commit_flush |-> commit_flush_pc == EXC_VECTOR)
		else value_error("commit_flush_pc", $sampled(commit_flush_pc), EXC_VECTOR);
	a_mul: assert property (@(posedge clk) disable iff (reset) commit_mul == exp_mul)
		else value_error("commit_mul", $sampled(commit_mul), $sampled(exp_mul));
	a_cp0: assert property (@(posedge clk) disable iff (reset) commit_cp0 == exp_cp0)
		else value_error("commit_cp0", $sampled(commit_cp0), $sampled(exp_cp0));
	a_branch: assert property (@(posedge clk) disable iff (reset) resolved_branch == exp_branch)
		else value_error("resolved_branch", $sampled(resolved_branch), $sampled(exp_branch));
	a_push: assert property (@(posedge clk) disable iff (reset)
		lsu_store_push == (rob_ack && exp_store))
		else value_error("lsu_store_push", $sampled(lsu_store_push),
			$sampled(rob_ack && exp_store));
	a_push_req: assert property (@(posedge clk) disable iff (reset)
		lsu_store_push |-> lsu_store_memreq == exp_memreq)
		else value_error("lsu_store_memreq", $sampled(lsu_store_memreq), $sampled(exp_memreq));
	a_sq_hold: assert property (@(posedge clk) disable iff (reset)
		(burst_phase && burst_pushes >= SQ_DEPTH && exp_store) |-> !rob_ack)
		else check_error("store committed while the store queue was full");
	a_load_latency: assert property (@(posedge clk) disable iff (reset)
		load_req.valid |=> load_resp.valid)
		else check_error("load response missing one cycle after the request");
	a_load_data: assert property (@(posedge clk) disable iff (reset)
		exp_load_check |-> load_resp.rdata === exp_load_data)
		else value_error("load_resp.rdata", $sampled(load_resp.rdata), $sampled(exp_load_data));

	function automatic rob_entry_t make_entry(input fu_t fu, input exc_code_t exc);
		rob_entry_t e;
		e = '0;
		e.dest = reg_addr_t'($random(seed));
		e.pc   = 32'h0040_0000 + 32'(exp_tail) * 4;
		e.fu   = fu;
		e.exc  = exc;
		if (fu == FU_STORE) begin
			e.data.memreq.addr  = 30'($random(seed) & 3);
			e.data.memreq.be    = 4'($random(seed));
			e.data.memreq.wdata = $random(seed);
		end else begin
			e.data.resolved_branch.valid  = 1'b1;
			e.data.resolved_branch.taken  = 1'($random(seed));
			e.data.resolved_branch.pc     = e.pc;
			e.data.resolved_branch.target = $random(seed);
		end
		return e;
	endfunction

	task automatic dispatch(input rob_entry_t e);
		int n;
		logic [3:0] idx;
		n = 0;
		@(negedge clk);
		while (rob_full) begin
			n++;
			if (n > TIMEOUT)
				timeout_error("rob_full to drop");
			@(negedge clk);
		end
		@(posedge clk);
		dispatch_valid <= 1'b1;
		dispatch_entry <= e;
		// tail that the next edge writes
		@(negedge clk);
		idx = dispatch_index;
		@(posedge clk);
		dispatch_valid <= 1'b0;
		@(negedge clk);
		exp_idx[exp_tail]       = idx;
		exp_mem[exp_tail]       = e;
		exp_mem[exp_tail].valid = 1'b1;
		exp_mem[exp_tail].busy  = 1'b1;
		exp_tail++;
	endtask

	task automatic write_back(input int pos);
		uint32_t v;
		v = $random(seed);
		@(posedge clk);
		wb_valid <= 1'b1;
		wb_index <= exp_idx[pos];
		wb_value <= v;
		@(posedge clk);
		wb_valid <= 1'b0;
		exp_mem[pos].value = v;
		exp_mem[pos].busy  = 1'b0;
		repeat ($unsigned($random(seed)) % 3) @(posedge clk);
	endtask

	task automatic write_back_range(input int first, input int n, input bit shuffle);
		int j, tmp;
		for (int i = 0; i < n; i++)
			order[i] = first + i;
		if (shuffle) begin
			for (int i = n - 1; i > 0; i--) begin
				j = $unsigned($random(seed)) % (i + 1);
				tmp = order[i];
				order[i] = order[j];
				order[j] = tmp;
			end
		end
		for (int i = 0; i < n; i++)
			write_back(order[i]);
	endtask

	task automatic wait_model_empty();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				timeout_error("all dispatched entries to commit");
		end while (exp_head != exp_tail);
	endtask

	task automatic wait_sq_empty();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				timeout_error("sq_empty");
		end while (!sq_empty);
	endtask

	task automatic wait_flush(input int start);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				timeout_error("commit_flush");
		end while (flush_count == start);
	endtask

	task automatic wait_pushes(input int target);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				timeout_error("the store queue to fill");
		end while (burst_pushes < target);
	endtask

	task automatic check_loads();
		check_load = 1'b1;
		for (int a = 0; a < 4; a++) begin
			@(posedge clk);
			load_req.valid <= 1'b1;
			load_req.addr  <= 30'(a);
			@(posedge clk);
			load_req.valid <= 1'b0;
			@(posedge clk);
		end
		@(negedge clk);
		check_load = 1'b0;
	endtask

	initial begin
		int base;
		int fl;
		seed           = 32'h14d3_03bd;
		reset          = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_entry = '0;
		wb_valid       = 1'b0;
		wb_index       = '0;
		wb_value       = '0;
		cp0_status     = '0;
		interrupt_flag = '0;
		load_req       = '0;
		exp_head       = 0;
		exp_tail       = 0;
		check_load     = 1'b0;
		burst_phase    = 1'b0;
		burst_pushes   = 0;
		flush_count    = 0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// out-of-order completion with in-order retire
		for (int round = 0; round < 3; round++) begin
			base = exp_tail;
			for (int i = 0; i < 10; i++)
				dispatch(make_entry(FU_ALU, EXC_NONE));
			write_back_range(base, 10, 1'b1);
			wait_model_empty();
		end

		base = exp_tail;
		dispatch(make_entry(FU_MUL, EXC_NONE));
		dispatch(make_entry(FU_BRANCH, EXC_NONE));
		dispatch(make_entry(FU_CP0, EXC_NONE));
		dispatch(make_entry(FU_ALU, EXC_NONE));
		dispatch(make_entry(FU_BRANCH, EXC_NONE));
		dispatch(make_entry(FU_MUL, EXC_NONE));
		write_back_range(base, 6, 1'b0);
		wait_model_empty();

		// stores alternate with alu ops for one store per packet
		base = exp_tail;
		for (int i = 0; i < 8; i++)
			dispatch(make_entry((i % 2 == 0) ? FU_STORE : FU_ALU, EXC_NONE));
		write_back_range(base, 8, 1'b1);
		wait_model_empty();
		wait_sq_empty();
		check_loads();

		// load port held busy so the queue cannot drain
		burst_pushes = 0;
		burst_phase  = 1'b1;
		@(posedge clk);
		load_req.valid <= 1'b1;
		load_req.addr  <= 30'h10;
		base = exp_tail;
		for (int i = 0; i < 12; i++)
			dispatch(make_entry((i % 2 == 0) ? FU_STORE : FU_ALU, EXC_NONE));
		write_back_range(base, 12, 1'b0);
		wait_pushes(SQ_DEPTH);
		repeat (6) @(posedge clk);
		if (exp_head == exp_tail)
			check_error("store burst never stalled on a full queue");
		load_req.valid <= 1'b0;
		burst_phase = 1'b0;
		wait_model_empty();
		wait_sq_empty();
		check_loads();

		// exception in the younger slot and then in the older one
		for (int k = 0; k < 2; k++) begin
			base = exp_tail;
			dispatch(make_entry(FU_ALU, (k == 0) ? EXC_NONE : EXC_SYS));
			dispatch(make_entry(FU_ALU, (k == 0) ? EXC_OV : EXC_NONE));
			dispatch(make_entry(FU_ALU, EXC_NONE));
			fl = flush_count;
			write_back(base + 2);
			write_back(base + 1);
			write_back(base);
			wait_flush(fl);
		end

		@(posedge clk);
		cp0_status     <= '{ie: 1'b1, im: 8'h04};
		interrupt_flag <= 8'h04;
		base = exp_tail;
		dispatch(make_entry(FU_ALU, EXC_NONE));
		dispatch(make_entry(FU_ALU, EXC_NONE));
		fl = flush_count;
		write_back(base + 1);
		write_back(base);
		wait_flush(fl);

		// masked interrupt line
		@(posedge clk);
		cp0_status.im <= 8'h00;
		base = exp_tail;
		dispatch(make_entry(FU_ALU, EXC_NONE));
		dispatch(make_entry(FU_ALU, EXC_NONE));
		write_back_range(base, 2, 1'b1);
		wait_model_empty();
		@(posedge clk);
		interrupt_flag <= 8'h00;
		repeat (4) @(posedge clk);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
src/mem_pkg.sv
src/cpu_pkg.sv
src/reorder_buffer.sv
src/except_detect.sv
src/instr_commit.sv
src/store_queue.sv
src/shared_dmem.sv
src/commit_top.sv
tb/commit_tb.sv

// File: Bender.yml
package:
  name: commit_subsystem

sources:
  - files:
      - src/mem_pkg.sv
      - src/cpu_pkg.sv
      - src/reorder_buffer.sv
      - src/except_detect.sv
      - src/instr_commit.sv
      - src/store_queue.sv
      - src/shared_dmem.sv
      - src/commit_top.sv
  - target: test
    files:
      - tb/commit_tb.sv
